//--- verilog/roc_pkg.sv
`default_nettype none

package roc_pkg;

    // Main CPU address map
    localparam logic [15:0] ROM_BASE    = 16'h6000;   // ROM runs up to FFFF
    localparam logic [6:0]  IO_RD_PAGE  = 7'h18;      // 3000-31FF on reads
    localparam logic [6:0]  IO_WR_PAGE  = 7'h40;      // 8000-81FF on writes
    localparam logic [4:0]  OBJRAM_PAGE = 5'b0100_0;  // 4000-47FF
    localparam logic [4:0]  VRAM_PAGE   = 5'b0100_1;  // 4800-4FFF
    localparam logic [3:0]  RAM_PAGE    = 4'h5;       // 5000-5FFF

    // A[8:7] inside the I/O page
    localparam logic [1:0] IO_SEL_VECTOR = 2'd3;
    localparam logic [1:0] IO_SEL_HIGH   = 2'd2;   // dip3 on reads, sound latch on writes
    localparam logic [1:0] IO_SEL_MID    = 2'd1;   // imux on reads, output latch on writes
    localparam logic [1:0] IO_SEL_LOW    = 2'd0;   // dip1 on reads only

    // Memory widths
    localparam int RAM_AW = 12;
    localparam int VEC_AW = 4;
    localparam int BUS_AW = 11;

    // Target of the current bus cycle
    typedef enum logic [3:0] {
        reg_none,
        reg_rom,
        reg_ram,
        reg_vram,
        reg_objram,
        reg_vector,
        reg_dip1,
        reg_dip3,
        reg_imux,
        reg_snd,
        reg_oreg,
        reg_error
    } region_t;

    // 74LS259 bit index, taken from A[2:0]
    typedef enum logic [2:0] {
        ob_flip    = 3'd0,
        ob_snd_on  = 3'd1,
        ob_mute    = 3'd2,
        ob_coin1   = 3'd3,
        ob_coin2   = 3'd4,
        ob_spare   = 3'd5,
        ob_firq_en = 3'd6,
        ob_irq_en  = 3'd7
    } oreg_bit_t;

endpackage

`default_nettype wire

//--- verilog/roc_addr_decode.sv
`default_nettype none

module roc_addr_decode (
    input  logic [15:0]      addr,
    input  logic             rnw,
    input  logic             vma,
    output roc_pkg::region_t region,
    output logic             rom_cs,
    output logic             vram_cs,
    output logic             objram_cs,
    output logic             bus_error
);

    logic       vector_rd;
    logic       io_page;
    logic [1:0] io_sel;

    // KONAMI-1 fetches its vectors from FFF0-FFFD, FFFE/F stay in ROM
    assign vector_rd = rnw && (&addr[15:4]) && !(&addr[3:1]);

    // The I/O page moves depending on the direction
    assign io_page = addr[15:9] == (rnw ? roc_pkg::IO_RD_PAGE : roc_pkg::IO_WR_PAGE);
    assign io_sel  = addr[8:7];

    always_comb begin
        region = roc_pkg::reg_error;   // Whatever is not claimed below
        if (!vma) begin
            region = roc_pkg::reg_none;
        end else if (vector_rd) begin
            region = roc_pkg::reg_vector;
        end else if (io_page) begin
            case (io_sel)
                roc_pkg::IO_SEL_VECTOR: region = roc_pkg::reg_vector;
                roc_pkg::IO_SEL_HIGH:   region = rnw ? roc_pkg::reg_dip3 : roc_pkg::reg_snd;
                roc_pkg::IO_SEL_MID:    region = rnw ? roc_pkg::reg_imux : roc_pkg::reg_oreg;
                roc_pkg::IO_SEL_LOW:    region = rnw ? roc_pkg::reg_dip1 : roc_pkg::reg_error;
                default:                region = roc_pkg::reg_error;
            endcase
        end else if (addr[15:11] == roc_pkg::OBJRAM_PAGE) begin
            region = roc_pkg::reg_objram;
        end else if (addr[15:11] == roc_pkg::VRAM_PAGE) begin
            region = roc_pkg::reg_vram;
        end else if (addr[15:12] == roc_pkg::RAM_PAGE) begin
            region = roc_pkg::reg_ram;
        end else if (rnw && addr >= roc_pkg::ROM_BASE) begin
            region = roc_pkg::reg_rom;   // ROM cannot be written
        end
    end

    // External selects come from the same code
    assign rom_cs    = region == roc_pkg::reg_rom;
    assign vram_cs   = region == roc_pkg::reg_vram;
    assign objram_cs = region == roc_pkg::reg_objram;
    assign bus_error = region == roc_pkg::reg_error;

endmodule

`default_nettype wire

//--- verilog/roc_cabinet_mux.sv
`default_nettype none

module roc_cabinet_mux (
    input  logic       clk,
    input  logic [1:0] sel,
    input  logic [1:0] start_button,
    input  logic [1:0] coin_input,
    input  logic       service,
    input  logic [5:0] joystick1,
    input  logic [5:0] joystick2,
    input  logic [7:0] dipsw_mid,
    output logic [7:0] cabinet
);

    logic [7:0] system_byte;
    logic [7:0] p1_byte;
    logic [7:0] p2_byte;

    // Unused bits read back high
    assign system_byte = {3'b111, start_button, service, coin_input};

    // Board wiring swaps the direction pairs
    assign p1_byte = {
        2'b11,
        joystick1[5:4],
        joystick1[2],
        joystick1[3],
        joystick1[0],
        joystick1[1]
    };

    assign p2_byte = {
        2'b11,
        joystick2[5:4],
        joystick2[2],
        joystick2[3],
        joystick2[0],
        joystick2[1]
    };

    always_ff @(posedge clk) begin
        case (sel)
            2'd0:    cabinet <= system_byte;
            2'd1:    cabinet <= p1_byte;
            2'd2:    cabinet <= p2_byte;
            default: cabinet <= dipsw_mid;   // DIP bank 2
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/roc_local_mem.sv
`default_nettype none

module roc_local_mem (
    input  logic             clk,
    input  logic [15:0]      addr,
    input  roc_pkg::region_t region,
    input  logic             rnw,
    input  logic             cpu_cen,
    input  logic [7:0]       cpu_dout,
    output logic [7:0]       ram_dout,
    output logic [7:0]       vec_dout
);

    localparam int RAM_DEPTH = 2 ** roc_pkg::RAM_AW;
    localparam int VEC_DEPTH = 2 ** roc_pkg::VEC_AW;

    logic [7:0] ram [0:RAM_DEPTH-1];
    logic [7:0] vectors [0:VEC_DEPTH-1];

    logic [roc_pkg::RAM_AW-1:0] ram_addr;
    logic [roc_pkg::VEC_AW-1:0] vec_addr;
    logic                       wr_strobe;
    logic                       ram_we;
    logic                       vec_we;

    assign ram_addr  = addr[roc_pkg::RAM_AW-1:0];
    assign vec_addr  = addr[roc_pkg::VEC_AW-1:0];
    assign wr_strobe = cpu_cen && !rnw;
    assign ram_we    = wr_strobe && region == roc_pkg::reg_ram;
    assign vec_we    = wr_strobe && region == roc_pkg::reg_vector;

    // Work RAM
    always_ff @(posedge clk) begin
        if (ram_we) begin
            ram[ram_addr] <= cpu_dout;
        end
        ram_dout <= ram[ram_addr];
    end

    // Vector table, written through the I/O page and read at FFF0
    always_ff @(posedge clk) begin
        if (vec_we) begin
            vectors[vec_addr] <= cpu_dout;
        end
        vec_dout <= vectors[vec_addr];
    end

endmodule

`default_nettype wire

//--- verilog/roc_ctrl_latch.sv
`default_nettype none

module roc_ctrl_latch (
    input  logic             clk,
    input  logic             rst,
    input  logic [2:0]       addr,
    input  roc_pkg::region_t region,
    input  logic             rnw,
    input  logic             cpu_cen,
    input  logic [7:0]       cpu_dout,
    input  logic             lvbl,
    input  logic             dip_pause,
    output logic             flip,
    output logic             snd_on,
    output logic             mute,
    output logic             coin1,
    output logic             coin2,
    output logic             firq_en,
    output logic             irq_en,
    output logic [7:0]       snd_latch,
    output logic             irq_n,
    output logic             firq_n
);

    logic                wr_strobe;
    logic                lvbl_l;
    logic                frame_odd;   // Frame parity
    logic                vb_fall;
    roc_pkg::oreg_bit_t  oreg_bit;

    assign wr_strobe = cpu_cen && !rnw;
    assign oreg_bit  = roc_pkg::oreg_bit_t'(addr);

    // Start of vertical blank, ignored while paused
    assign vb_fall = lvbl_l && !lvbl && dip_pause;

    // 74LS259 addressable latch and sound latch
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flip      <= 1'b0;
            snd_on    <= 1'b0;
            mute      <= 1'b0;
            coin1     <= 1'b0;
            coin2     <= 1'b0;
            firq_en   <= 1'b0;
            irq_en    <= 1'b0;
            snd_latch <= 8'h00;
        end else if (wr_strobe) begin
            if (region == roc_pkg::reg_snd) begin
                snd_latch <= cpu_dout;
            end
            if (region == roc_pkg::reg_oreg) begin
                case (oreg_bit)
                    roc_pkg::ob_flip:    flip    <= cpu_dout[0];
                    roc_pkg::ob_snd_on:  snd_on  <= cpu_dout[0];
                    roc_pkg::ob_mute:    mute    <= cpu_dout[0];
                    roc_pkg::ob_coin1:   coin1   <= cpu_dout[0];
                    roc_pkg::ob_coin2:   coin2   <= cpu_dout[0];
                    roc_pkg::ob_firq_en: firq_en <= cpu_dout[0];
                    roc_pkg::ob_irq_en:  irq_en  <= cpu_dout[0];
                    roc_pkg::ob_spare:   ;   // Output not connected
                    default:             ;
                endcase
            end
        end
    end

    // IRQ set by vblank, held until the enable drops
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            irq_n <= 1'b1;
        end else if (!irq_en) begin
            irq_n <= 1'b1;
        end else if (vb_fall) begin
            irq_n <= 1'b0;
        end
    end

    // FIRQ on every other frame
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lvbl_l    <= 1'b0;
            frame_odd <= 1'b0;
            firq_n    <= 1'b1;
        end else begin
            lvbl_l <= lvbl;
            if (vb_fall) begin
                frame_odd <= ~frame_odd;
                if (!frame_odd) begin
                    firq_n <= 1'b0;   // First frame after reset fires
                end
            end
            // Release wins over a new request
            if (!firq_en || !dip_pause) begin
                firq_n <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/roc_read_mux.sv
`default_nettype none

module roc_read_mux (
    input  logic             clk,
    input  roc_pkg::region_t region,
    input  logic [7:0]       rom_data,
    input  logic [7:0]       vram_dout,
    input  logic [7:0]       obj_dout,
    input  logic [7:0]       ram_dout,
    input  logic [7:0]       vec_dout,
    input  logic [7:0]       cabinet,
    input  logic [23:0]      dipsw,
    output logic [7:0]       cpu_din
);

    logic [7:0] rd_byte;

    always_comb begin
        case (region)
            roc_pkg::reg_rom:    rd_byte = rom_data;
            roc_pkg::reg_vram:   rd_byte = vram_dout;
            roc_pkg::reg_objram: rd_byte = obj_dout;
            roc_pkg::reg_ram:    rd_byte = ram_dout;    // Already registered
            roc_pkg::reg_vector: rd_byte = vec_dout;    // Already registered
            roc_pkg::reg_imux:   rd_byte = cabinet;     // Already registered
            roc_pkg::reg_dip1:   rd_byte = dipsw[7:0];
            roc_pkg::reg_dip3:   rd_byte = dipsw[23:16];
            default:             rd_byte = 8'hff;       // Open bus
        endcase
    end

    always_ff @(posedge clk) begin
        cpu_din <= rd_byte;
    end

endmodule

`default_nettype wire

//--- verilog/roc_main_bus.sv
`default_nettype none

module roc_main_bus (
    input  logic                       clk,
    input  logic                       rst,

    // CPU bus
    input  logic [15:0]                addr,
    input  logic                       rnw,
    input  logic                       vma,
    input  logic                       cpu_cen,
    input  logic [7:0]                 cpu_dout,
    output logic [7:0]                 cpu_din,

    // ROM
    output logic [15:0]                rom_addr,
    output logic                       rom_cs,
    input  logic [7:0]                 rom_data,

    // Video memories
    output logic [roc_pkg::BUS_AW-1:0] bus_addr,
    output logic                       vram_cs,
    output logic                       objram_cs,
    input  logic [7:0]                 vram_dout,
    input  logic [7:0]                 obj_dout,

    // Cabinet
    input  logic [1:0]                 start_button,
    input  logic [1:0]                 coin_input,
    input  logic [5:0]                 joystick1,
    input  logic [5:0]                 joystick2,
    input  logic                       service,
    input  logic                       dip_pause,
    input  logic [23:0]                dipsw,
    input  logic                       lvbl,

    // Latches and status
    output logic [7:0]                 snd_latch,
    output logic                       snd_on,
    output logic                       mute,
    output logic                       flip,
    output logic                       coin1,
    output logic                       coin2,
    output logic                       irq_n,
    output logic                       firq_n,
    output logic [7:0]                 st_dout
);

    roc_pkg::region_t region;
    logic             bus_error;
    logic [7:0]       cabinet;
    logic [7:0]       ram_dout;
    logic [7:0]       vec_dout;
    logic             firq_en;
    logic             irq_en;

    assign rom_addr = addr - roc_pkg::ROM_BASE;
    assign bus_addr = addr[roc_pkg::BUS_AW-1:0];
    assign st_dout  = {2'b00, bus_error, mute, snd_on, flip, firq_en, irq_en};

    roc_addr_decode u_decode (
        .addr      (addr),
        .rnw       (rnw),
        .vma       (vma),
        .region    (region),
        .rom_cs    (rom_cs),
        .vram_cs   (vram_cs),
        .objram_cs (objram_cs),
        .bus_error (bus_error)
    );

    roc_cabinet_mux u_cabinet (
        .clk          (clk),
        .sel          (addr[1:0]),
        .start_button (start_button),
        .coin_input   (coin_input),
        .service      (service),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .dipsw_mid    (dipsw[15:8]),
        .cabinet      (cabinet)
    );

    roc_local_mem u_mem (
        .clk      (clk),
        .addr     (addr),
        .region   (region),
        .rnw      (rnw),
        .cpu_cen  (cpu_cen),
        .cpu_dout (cpu_dout),
        .ram_dout (ram_dout),
        .vec_dout (vec_dout)
    );

    roc_ctrl_latch u_latch (
        .clk       (clk),
        .rst       (rst),
        .addr      (addr[2:0]),
        .region    (region),
        .rnw       (rnw),
        .cpu_cen   (cpu_cen),
        .cpu_dout  (cpu_dout),
        .lvbl      (lvbl),
        .dip_pause (dip_pause),
        .flip      (flip),
        .snd_on    (snd_on),
        .mute      (mute),
        .coin1     (coin1),
        .coin2     (coin2),
        .firq_en   (firq_en),
        .irq_en    (irq_en),
        .snd_latch (snd_latch),
        .irq_n     (irq_n),
        .firq_n    (firq_n)
    );

    roc_read_mux u_rdmux (
        .clk       (clk),
        .region    (region),
        .rom_data  (rom_data),
        .vram_dout (vram_dout),
        .obj_dout  (obj_dout),
        .ram_dout  (ram_dout),
        .vec_dout  (vec_dout),
        .cabinet   (cabinet),
        .dipsw     (dipsw),
        .cpu_din   (cpu_din)
    );

endmodule

`default_nettype wire

//--- tb/roc_main_bus_tb.sv
`default_nettype none

module roc_main_bus_tb;

    timeunit 1ns;
    timeprecision 1ps;

    logic        clk;
    logic        rst;
    logic [15:0] addr;
    logic        rnw;
    logic        vma;
    logic        cpu_cen;
    logic [7:0]  cpu_dout;
    logic [7:0]  cpu_din;
    logic [15:0] rom_addr;
    logic        rom_cs;
    logic [7:0]  rom_data;
    logic [10:0] bus_addr;
    logic        vram_cs;
    logic        objram_cs;
    logic [7:0]  vram_dout;
    logic [7:0]  obj_dout;
    logic [1:0]  start_button;
    logic [1:0]  coin_input;
    logic [5:0]  joystick1;
    logic [5:0]  joystick2;
    logic        service;
    logic        dip_pause;
    logic [23:0] dipsw;
    logic        lvbl;
    logic [7:0]  snd_latch;
    logic        snd_on;
    logic        mute;
    logic        flip;
    logic        coin1;
    logic        coin2;
    logic        irq_n;
    logic        firq_n;
    logic [7:0]  st_dout;

    logic [31:0] seed = 32'h14e8_3feb;
    logic [31:0] rnd;
    logic [15:0] a;
    logic [15:0] rom_exp;
    logic [7:0]  exp_oreg;   // Expected latch bits, by A[2:0]
    logic [15:0] ram_addr_list [16];
    logic [7:0]  ram_data [16];
    logic [7:0]  vec_data [16];
    int          frame_count = 0;   // Vblank falls seen while not paused

    roc_main_bus i_dut (.*);

    // Memory models on the external buses
    function automatic logic [7:0] rom_byte(input logic [15:0] ra);
        return ra[7:0] ^ ra[15:8] ^ 8'h5a;
    endfunction

    function automatic logic [7:0] vram_byte(input logic [10:0] va);
        return (va[7:0] + {5'b00000, va[10:8]}) ^ 8'hc3;
    endfunction

    function automatic logic [7:0] obj_byte(input logic [10:0] va);
        return ~va[7:0] ^ {va[10:8], 5'b00000};
    endfunction

    assign rom_data  = rom_byte(rom_addr);
    assign vram_dout = vram_byte(bus_addr);
    assign obj_dout  = obj_byte(bus_addr);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // Expected {rom_cs, vram_cs, objram_cs, bus_error}
    function automatic logic [3:0] expected_selects(input logic [15:0] ea, input logic r);
        if (r && ea >= 16'hfff0 && ea <= 16'hfffd) return 4'b0000;   // Vector fetch
        if (ea[15:9] == (r ? 7'h18 : 7'h40)) return (!r && ea[8:7] == 2'd0) ? 4'b0001 : 4'b0000;
        if (ea >= 16'h4000 && ea <= 16'h47ff) return 4'b0010;
        if (ea >= 16'h4800 && ea <= 16'h4fff) return 4'b0100;
        if (ea >= 16'h5000 && ea <= 16'h5fff) return 4'b0000;
        if (r && ea >= 16'h6000) return 4'b1000;
        return 4'b0001;
    endfunction

    function automatic logic [15:0] random_address(input logic [31:0] r);
        case (r[18:16])
            3'd0:    return {7'h18, r[8:0]};
            3'd1:    return {7'h40, r[8:0]};
            3'd2:    return {12'hfff, r[3:0]};
            3'd3:    return {3'b010, r[12:0]};
            3'd4:    return {4'h3, r[11:0]};
            default: return r[15:0];
        endcase
    endfunction

    function automatic logic [7:0] cabinet_byte(input logic [1:0] sel);
        case (sel)
            2'd0:    return {3'b111, start_button, service, coin_input};
            2'd1:    return {2'b11, joystick1[5:4], joystick1[2], joystick1[3],
                             joystick1[0], joystick1[1]};
            2'd2:    return {2'b11, joystick2[5:4], joystick2[2], joystick2[3],
                             joystick2[0], joystick2[1]};
            default: return dipsw[15:8];
        endcase
    endfunction

    task automatic fail_message(input string msg);
        $display("%s at t=%0t", msg, $time);
        $display("=== FAIL ===");
        $fatal(1, "stopped");
    endtask

    task automatic fail_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        $display("ERR t=%0t %s expected %0h got %0h", $time, name, exp, act);
        $display("=== FAIL ===");
        $fatal(1, "stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else fail_value(name, exp, act);
    endtask

    // Interrupt lines release one edge after their enable or the pause drops
    assert property (@(negedge clk) disable iff (rst)
        ($past(st_dout[0]) || irq_n) &&
        (($past(st_dout[1]) && $past(dip_pause)) || firq_n))
        else fail_message("interrupt still asserted after its enable or pause dropped");

    task automatic apply_address(input logic [15:0] ta, input logic r);
        @(posedge clk);
        addr    <= ta;
        rnw     <= r;
        vma     <= 1'b1;
        cpu_cen <= 1'b0;
        @(negedge clk);
    endtask

    task automatic bus_read(input logic [15:0] ta, output logic [7:0] td);
        apply_address(ta, 1'b1);
        @(posedge clk);
        @(posedge clk);
        cpu_cen <= 1'b1;   // End of the cycle
        @(posedge clk);
        cpu_cen <= 1'b0;
        vma     <= 1'b0;
        @(negedge clk);
        td = cpu_din;
    endtask

    task automatic bus_write(input logic [15:0] ta, input logic [7:0] td);
        @(posedge clk);
        addr     <= ta;
        rnw      <= 1'b0;
        vma      <= 1'b1;
        cpu_dout <= td;
        cpu_cen  <= 1'b1;
        @(posedge clk);   // Strobe taken here
        cpu_cen  <= 1'b0;
        vma      <= 1'b0;
        rnw      <= 1'b1;
        @(negedge clk);
    endtask

    task automatic read_expect(input string name, input logic [15:0] ta, input logic [7:0] exp);
        logic [7:0] got;
        bus_read(ta, got);
        check_value(name, 32'(exp), 32'(got));
    endtask

    task automatic check_latches();
        check_value("flip", 32'(exp_oreg[0]), 32'(flip));
        check_value("snd_on", 32'(exp_oreg[1]), 32'(snd_on));
        check_value("mute", 32'(exp_oreg[2]), 32'(mute));
        check_value("coin1", 32'(exp_oreg[3]), 32'(coin1));
        check_value("coin2", 32'(exp_oreg[4]), 32'(coin2));
        check_value("st_dout", 32'({3'b000, exp_oreg[2], exp_oreg[1], exp_oreg[0],
                    exp_oreg[6], exp_oreg[7]}), 32'(st_dout));
    endtask

    task automatic wait_interrupt(input logic fast, input logic level, input int limit);
        int n;
        n = 0;
        while ((fast ? firq_n : irq_n) !== level && n < limit) begin
            @(negedge clk);
            n++;
        end
        if ((fast ? firq_n : irq_n) !== level) begin
            fail_message($sformatf("%s did not go to %0b", fast ? "firq_n" : "irq_n", level));
        end
    endtask

    task automatic vblank_fall();
        @(posedge clk);
        lvbl <= 1'b0;
        if (dip_pause) frame_count++;
    endtask

    task automatic vblank_rise();
        repeat (3) @(posedge clk);
        lvbl <= 1'b1;
        repeat (2) @(posedge clk);
    endtask

    task automatic firq_frame();
        logic fire;
        fire = !frame_count[0];   // Odd frames counted from one
        vblank_fall();
        if (fire) begin
            wait_interrupt(1'b1, 1'b0, 4);
            bus_write(16'h8086, 8'h00);
            wait_interrupt(1'b1, 1'b1, 4);
            bus_write(16'h8086, 8'h01);
        end else begin
            repeat (6) begin
                @(negedge clk);
                check_value("firq_n", 32'd1, 32'(firq_n));
            end
        end
        check_value("irq_n", 32'd1, 32'(irq_n));
        vblank_rise();
    endtask

    initial begin
        repeat (100000) @(posedge clk);
        fail_message("simulation did not finish in time");
    end

    initial begin
        rst = 1'b1;
        addr = 16'h0000;
        rnw = 1'b1;
        vma = 1'b0;
        cpu_cen = 1'b0;
        cpu_dout = 8'h00;
        start_button = 2'b11;
        coin_input = 2'b11;
        joystick1 = 6'h3f;
        joystick2 = 6'h3f;
        service = 1'b1;
        dip_pause = 1'b1;
        dipsw = 24'hffffff;
        lvbl = 1'b1;
        exp_oreg = 8'h00;

        // Reset state, during and after
        for (int c = 0; c < 5; c++) begin
            @(negedge clk);
            check_latches();
            check_value("snd_latch", 32'd0, 32'(snd_latch));
            check_value("irq_n", 32'd1, 32'(irq_n));
            check_value("firq_n", 32'd1, 32'(firq_n));
            if (c == 2) begin
                @(posedge clk);   // Fourth rising edge under reset
                rst <= 1'b0;
            end
        end

        // Address decode
        repeat (300) begin
            rnd = next_random();
            a = random_address(rnd);
            apply_address(a, rnd[20]);
            check_value("selects", 32'(expected_selects(a, rnd[20])),
                        32'({rom_cs, vram_cs, objram_cs, st_dout[5]}));
            check_value("bus_addr", 32'(a[10:0]), 32'(bus_addr));
            rom_exp = a - 16'h6000;
            if (rom_cs) check_value("rom_addr", 32'(rom_exp), 32'(rom_addr));
            @(posedge clk);
            vma <= 1'b0;
            @(negedge clk);
            check_value("selects", 32'd0, 32'({rom_cs, vram_cs, objram_cs, st_dout[5]}));
        end

        // Work RAM and vector table
        for (int i = 0; i < 16; i++) begin
            rnd = next_random();
            ram_addr_list[i] = {4'h5, 4'(i), rnd[7:0]};
            ram_data[i] = rnd[15:8];
            vec_data[i] = rnd[23:16];
            bus_write(ram_addr_list[i], ram_data[i]);
            bus_write(16'h8180 | 16'(i), vec_data[i]);
        end
        for (int i = 0; i < 16; i++) begin
            read_expect("ram", ram_addr_list[i], ram_data[i]);
            read_expect("vector io", 16'h3180 | 16'(i), vec_data[i]);
            if (i < 14) read_expect("vector fetch", 16'hfff0 | 16'(i), vec_data[i]);
        end
        read_expect("rom", 16'hfffe, rom_byte(16'hfffe - 16'h6000));
        repeat (8) begin
            rnd = next_random();
            a = {3'b011, rnd[12:0]};
            read_expect("rom", a, rom_byte(a - 16'h6000));
            read_expect("vram", {5'b01001, rnd[26:16]}, vram_byte(rnd[26:16]));
            read_expect("objram", {5'b01000, rnd[26:16]}, obj_byte(rnd[26:16]));
            read_expect("unmapped", {4'h1, rnd[11:0]}, 8'hff);
        end

        // Cabinet inputs and DIP switches
        repeat (4) begin
            rnd = next_random();
            @(posedge clk);
            start_button <= rnd[1:0];
            coin_input   <= rnd[3:2];
            service      <= rnd[4];
            joystick1    <= rnd[10:5];
            joystick2    <= rnd[16:11];
            dipsw        <= 24'(next_random() >> 8);
            @(negedge clk);
            read_expect("dip1", 16'h3000, dipsw[7:0]);
            read_expect("dip3", 16'h3100, dipsw[23:16]);
            for (int s = 0; s < 4; s++) begin
                read_expect("imux", 16'h3080 | 16'(s), cabinet_byte(2'(s)));
            end
        end

        // Output latch bits, spare included
        for (int b = 0; b < 8; b++) begin
            rnd = next_random();
            bus_write(16'h8080 | 16'(b), {rnd[7:1], 1'b1});
            exp_oreg[b] = (b != 5);
            check_latches();
            bus_write(16'h8080 | 16'(b), {rnd[15:9], 1'b0});
            exp_oreg[b] = 1'b0;
            check_latches();
        end
        rnd = next_random();
        bus_write(16'h8100 | 16'(rnd[14:8]), rnd[7:0]);
        check_value("snd_latch", 32'(rnd[7:0]), 32'(snd_latch));
        apply_address(16'h1234, 1'b1);
        check_value("st_dout", 32'h20, 32'(st_dout));   // Bus error while held
        read_expect("unmapped", 16'h1234, 8'hff);

        // FIRQ on odd frames
        bus_write(16'h8086, 8'h01);
        repeat (5) firq_frame();
        bus_write(16'h8086, 8'h00);

        // IRQ every frame until cleared
        bus_write(16'h8087, 8'h01);
        repeat (3) begin
            vblank_fall();
            wait_interrupt(1'b0, 1'b0, 4);
            vblank_rise();
            check_value("irq_n", 32'd0, 32'(irq_n));
            bus_write(16'h8087, 8'h00);
            wait_interrupt(1'b0, 1'b1, 4);
            bus_write(16'h8087, 8'h01);
        end

        // Paused, no interrupts and no frame count
        @(posedge clk);
        dip_pause <= 1'b0;
        bus_write(16'h8086, 8'h01);
        vblank_fall();
        repeat (6) begin
            @(negedge clk);
            check_value("irq_n", 32'd1, 32'(irq_n));
            check_value("firq_n", 32'd1, 32'(firq_n));
        end
        vblank_rise();
        bus_write(16'h8087, 8'h00);
        @(posedge clk);
        dip_pause <= 1'b1;
        firq_frame();

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
verilog/roc_pkg.sv
verilog/roc_addr_decode.sv
verilog/roc_cabinet_mux.sv
verilog/roc_local_mem.sv
verilog/roc_ctrl_latch.sv
verilog/roc_read_mux.sv
verilog/roc_main_bus.sv
tb/roc_main_bus_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the roc_main_bus testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f all.f \
    --top-module roc_main_bus_tb \
    -Mdir obj_dir \
    -o sim_roc_main_bus

./obj_dir/sim_roc_main_bus
